// File: src/axil_mem_defs.svh
`ifndef AXIL_MEM_DEFS_SVH
`define AXIL_MEM_DEFS_SVH

// Byte address width of the AXI4-Lite port
`define AXIL_ADDR_WIDTH 32

// Data bus width and its byte-lane count
`define AXIL_DATA_WIDTH 32
`define AXIL_STRB_WIDTH (`AXIL_DATA_WIDTH / 8)

// Entries in each client channel FIFO
`define AXIL_FIFO_ELS 4

// Scratchpad depth in data words
`define MEM_WORDS 256

`endif

// File: src/axil_mem_pkg.sv
`default_nettype none

`include "axil_mem_defs.svh"

package axil_mem_pkg;

  // Bus payload vectors
  typedef logic [`AXIL_ADDR_WIDTH-1:0] axil_addr_t;
  typedef logic [`AXIL_DATA_WIDTH-1:0] axil_data_t;
  typedef logic [`AXIL_STRB_WIDTH-1:0] axil_strb_t;

  // AXI response codes of which only OKAY is produced here
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  typedef logic [2:0] axi_prot_t;

  // Response slot of the memory target
  typedef enum logic {
    RESP_IDLE  = 1'b0,
    RESP_VALID = 1'b1
  } mem_resp_state_e;

endpackage

`default_nettype wire

// File: src/axil_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module axil_fifo #(
  parameter int unsigned width_p = 8,
  parameter int unsigned els_p   = 4
) (
  input  wire                clk_i,
  input  wire                rst_n_i,

  input  wire  [width_p-1:0] data_i,
  input  wire                v_i,
  output logic               ready_o,

  output logic [width_p-1:0] data_o,
  output logic               v_o,
  input  wire                yumi_i
);

  localparam int unsigned ptr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int unsigned cnt_w_lp = $clog2(els_p + 1);

  logic [width_p-1:0]  mem_r [els_p];
  logic [ptr_w_lp-1:0] rd_ptr_r;
  logic [ptr_w_lp-1:0] wr_ptr_r;
  logic [cnt_w_lp-1:0] count_r;
  logic                push;
  logic                pop;

  // Pointer step with wrap at the last entry
  function automatic logic [ptr_w_lp-1:0] ptr_inc(input logic [ptr_w_lp-1:0] ptr);
    if (ptr == ptr_w_lp'(els_p - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign ready_o = (count_r != cnt_w_lp'(els_p));
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rd_ptr_r];

  assign push = v_i & ready_o;
  assign pop  = yumi_i & v_o;

  // Storage written at the tail
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= ptr_inc(wr_ptr_r);
      end
      if (pop) begin
        rd_ptr_r <= ptr_inc(rd_ptr_r);
      end
      // Occupancy holds when push and pop coincide
      if (push && !pop) begin
        count_r <= count_r + 1'b1;
      end else if (pop && !push) begin
        count_r <= count_r - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/axil_fifo_client.sv
`timescale 1ns/10ps
`default_nettype none

module axil_fifo_client #(
  parameter int unsigned fifo_els_p = 4
) (
  input  wire                            clk_i,
  input  wire                            rst_n_i,

  // Write address channel
  input  wire axil_mem_pkg::axil_addr_t  s_axil_awaddr_i,
  input  wire axil_mem_pkg::axi_prot_t   s_axil_awprot_i,
  input  wire                            s_axil_awvalid_i,
  output logic                           s_axil_awready_o,

  // Write data channel
  input  wire axil_mem_pkg::axil_data_t  s_axil_wdata_i,
  input  wire axil_mem_pkg::axil_strb_t  s_axil_wstrb_i,
  input  wire                            s_axil_wvalid_i,
  output logic                           s_axil_wready_o,

  // Write response channel
  output axil_mem_pkg::axi_resp_e        s_axil_bresp_o,
  output logic                           s_axil_bvalid_o,
  input  wire                            s_axil_bready_i,

  // Read address channel
  input  wire axil_mem_pkg::axil_addr_t  s_axil_araddr_i,
  input  wire axil_mem_pkg::axi_prot_t   s_axil_arprot_i,
  input  wire                            s_axil_arvalid_i,
  output logic                           s_axil_arready_o,

  // Read data channel
  output axil_mem_pkg::axil_data_t       s_axil_rdata_o,
  output axil_mem_pkg::axi_resp_e        s_axil_rresp_o,
  output logic                           s_axil_rvalid_o,
  input  wire                            s_axil_rready_i,

  // Request toward the memory
  output axil_mem_pkg::axil_addr_t       addr_o,
  output axil_mem_pkg::axil_data_t       data_o,
  output axil_mem_pkg::axil_strb_t       wmask_o,
  output logic                           v_o,
  output logic                           w_o,
  input  wire                            ready_and_i,

  // Response from the memory
  input  wire axil_mem_pkg::axil_data_t  data_i,
  input  wire                            v_i,
  output logic                           ready_and_o
);

  import axil_mem_pkg::*;

  localparam int unsigned strb_w_lp  = $bits(axil_strb_t);
  localparam int unsigned wfifo_w_lp = strb_w_lp + $bits(axil_data_t);

  axil_addr_t araddr_lo;
  axil_addr_t awaddr_lo;
  axil_data_t wdata_lo;
  axil_strb_t wmask_lo;
  logic       araddr_v_lo;
  logic       awaddr_v_lo;
  logic       wdata_v_lo;
  logic       araddr_yumi_li;
  logic       awaddr_yumi_li;
  logic       wdata_yumi_li;
  logic       return_ready_lo;
  logic       return_w_lo;
  logic       return_v_lo;
  logic       return_yumi_li;
  logic       req_fire;

  assign s_axil_bresp_o = OKAY;
  assign s_axil_rresp_o = OKAY;

  axil_fifo #(.width_p($bits(axil_addr_t)), .els_p(fifo_els_p)) araddr_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (s_axil_araddr_i),
    .v_i     (s_axil_arvalid_i),
    .ready_o (s_axil_arready_o),
    .data_o  (araddr_lo),
    .v_o     (araddr_v_lo),
    .yumi_i  (araddr_yumi_li)
  );

  axil_fifo #(.width_p($bits(axil_addr_t)), .els_p(fifo_els_p)) awaddr_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (s_axil_awaddr_i),
    .v_i     (s_axil_awvalid_i),
    .ready_o (s_axil_awready_o),
    .data_o  (awaddr_lo),
    .v_o     (awaddr_v_lo),
    .yumi_i  (awaddr_yumi_li)
  );

  // Strobe rides above the data word
  axil_fifo #(.width_p(wfifo_w_lp), .els_p(fifo_els_p)) wdata_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  ({s_axil_wstrb_i, s_axil_wdata_i}),
    .v_i     (s_axil_wvalid_i),
    .ready_o (s_axil_wready_o),
    .data_o  ({wmask_lo, wdata_lo}),
    .v_o     (wdata_v_lo),
    .yumi_i  (wdata_yumi_li)
  );

  // One bit per issued request that is set for writes
  axil_fifo #(.width_p(1), .els_p(fifo_els_p)) return_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (w_o),
    .v_i     (req_fire),
    .ready_o (return_ready_lo),
    .data_o  (return_w_lo),
    .v_o     (return_v_lo),
    .yumi_i  (return_yumi_li)
  );

  // Reads win over writes; a write needs both heads
  assign v_o      = return_ready_lo & (araddr_v_lo | (awaddr_v_lo & wdata_v_lo));
  assign w_o      = ~araddr_v_lo;
  assign req_fire = v_o & ready_and_i;

  // Read addresses are word aligned
  assign addr_o  = araddr_v_lo ? (araddr_lo & ~axil_addr_t'(strb_w_lp - 1)) : awaddr_lo;
  assign data_o  = wdata_lo;
  assign wmask_o = wmask_lo;

  assign araddr_yumi_li = req_fire & araddr_v_lo;
  assign awaddr_yumi_li = req_fire & ~araddr_v_lo;
  assign wdata_yumi_li  = awaddr_yumi_li;

  // Steer the response by the oldest outstanding request
  assign s_axil_rdata_o  = data_i;
  assign s_axil_rvalid_o = v_i & return_v_lo & ~return_w_lo;
  assign s_axil_bvalid_o = v_i & return_v_lo & return_w_lo;

  assign ready_and_o    = return_v_lo & (return_w_lo ? s_axil_bready_i : s_axil_rready_i);
  assign return_yumi_li = ready_and_o & v_i;

endmodule

`default_nettype wire

// File: src/axil_scratch_mem.sv
`timescale 1ns/10ps
`default_nettype none

module axil_scratch_mem #(
  parameter int unsigned words_p = 256
) (
  input  wire                            clk_i,
  input  wire                            rst_n_i,

  // Request port
  input  wire                            req_v_i,
  input  wire                            req_w_i,
  input  wire axil_mem_pkg::axil_addr_t  req_addr_i,
  input  wire axil_mem_pkg::axil_data_t  req_data_i,
  input  wire axil_mem_pkg::axil_strb_t  req_mask_i,
  output logic                           req_ready_and_o,

  // Response port
  output logic                           rsp_v_o,
  output axil_mem_pkg::axil_data_t       rsp_data_o,
  input  wire                            rsp_ready_and_i
);

  import axil_mem_pkg::*;

  localparam int unsigned lanes_lp = $bits(axil_strb_t);
  localparam int unsigned off_w_lp = $clog2(lanes_lp);
  localparam int unsigned idx_w_lp = (words_p > 1) ? $clog2(words_p) : 1;

  axil_data_t          mem_r [words_p];
  axil_addr_t          word_addr;
  logic [idx_w_lp-1:0] word_idx;
  mem_resp_state_e     state_r;
  mem_resp_state_e     state_n;
  logic                accept;
  logic                drain;

  // Drop the byte offset, then wrap onto the array
  assign word_addr = req_addr_i >> off_w_lp;
  assign word_idx  = idx_w_lp'(word_addr % words_p);

  assign rsp_v_o         = (state_r == RESP_VALID);
  assign drain           = rsp_v_o & rsp_ready_and_i;
  // Slot may refill in the cycle it empties
  assign req_ready_and_o = (state_r == RESP_IDLE) | drain;
  assign accept          = req_v_i & req_ready_and_o;

  always_comb begin
    state_n = state_r;
    unique case (state_r)
      RESP_IDLE: begin
        if (accept) begin
          state_n = RESP_VALID;
        end
      end
      RESP_VALID: begin
        if (drain && !accept) begin
          state_n = RESP_IDLE;
        end
      end
      default: state_n = RESP_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r <= RESP_IDLE;
    end else begin
      state_r <= state_n;
    end
  end

  // Byte-lane write, word read into the response register
  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (req_w_i) begin
        for (int b = 0; b < lanes_lp; b++) begin
          if (req_mask_i[b]) begin
            mem_r[word_idx][8*b +: 8] <= req_data_i[8*b +: 8];
          end
        end
        rsp_data_o <= '0;
      end else begin
        rsp_data_o <= mem_r[word_idx];
      end
    end
  end

endmodule

`default_nettype wire

// File: src/axil_mem_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "axil_mem_defs.svh"

module axil_mem_top (
  input  wire                            clk_i,
  input  wire                            rst_n_i,

  input  wire axil_mem_pkg::axil_addr_t  s_axil_awaddr_i,
  input  wire axil_mem_pkg::axi_prot_t   s_axil_awprot_i,
  input  wire                            s_axil_awvalid_i,
  output logic                           s_axil_awready_o,

  input  wire axil_mem_pkg::axil_data_t  s_axil_wdata_i,
  input  wire axil_mem_pkg::axil_strb_t  s_axil_wstrb_i,
  input  wire                            s_axil_wvalid_i,
  output logic                           s_axil_wready_o,

  output axil_mem_pkg::axi_resp_e        s_axil_bresp_o,
  output logic                           s_axil_bvalid_o,
  input  wire                            s_axil_bready_i,

  input  wire axil_mem_pkg::axil_addr_t  s_axil_araddr_i,
  input  wire axil_mem_pkg::axi_prot_t   s_axil_arprot_i,
  input  wire                            s_axil_arvalid_i,
  output logic                           s_axil_arready_o,

  output axil_mem_pkg::axil_data_t       s_axil_rdata_o,
  output axil_mem_pkg::axi_resp_e        s_axil_rresp_o,
  output logic                           s_axil_rvalid_o,
  input  wire                            s_axil_rready_i
);

  import axil_mem_pkg::*;

  // Request and response links between bridge and memory
  axil_addr_t req_addr;
  axil_data_t req_data;
  axil_strb_t req_mask;
  logic       req_v;
  logic       req_w;
  logic       req_ready_and;
  axil_data_t rsp_data;
  logic       rsp_v;
  logic       rsp_ready_and;

  axil_fifo_client #(.fifo_els_p(`AXIL_FIFO_ELS)) u_client (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .s_axil_awaddr_i  (s_axil_awaddr_i),
    .s_axil_awprot_i  (s_axil_awprot_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_wdata_i   (s_axil_wdata_i),
    .s_axil_wstrb_i   (s_axil_wstrb_i),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_bresp_o   (s_axil_bresp_o),
    .s_axil_bvalid_o  (s_axil_bvalid_o),
    .s_axil_bready_i  (s_axil_bready_i),
    .s_axil_araddr_i  (s_axil_araddr_i),
    .s_axil_arprot_i  (s_axil_arprot_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .s_axil_rdata_o   (s_axil_rdata_o),
    .s_axil_rresp_o   (s_axil_rresp_o),
    .s_axil_rvalid_o  (s_axil_rvalid_o),
    .s_axil_rready_i  (s_axil_rready_i),
    .addr_o           (req_addr),
    .data_o           (req_data),
    .wmask_o          (req_mask),
    .v_o              (req_v),
    .w_o              (req_w),
    .ready_and_i      (req_ready_and),
    .data_i           (rsp_data),
    .v_i              (rsp_v),
    .ready_and_o      (rsp_ready_and)
  );

  axil_scratch_mem #(.words_p(`MEM_WORDS)) u_mem (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .req_v_i         (req_v),
    .req_w_i         (req_w),
    .req_addr_i      (req_addr),
    .req_data_i      (req_data),
    .req_mask_i      (req_mask),
    .req_ready_and_o (req_ready_and),
    .rsp_v_o         (rsp_v),
    .rsp_data_o      (rsp_data),
    .rsp_ready_and_i (rsp_ready_and)
  );

endmodule

`default_nettype wire

// File: verification/axil_mem_sva.sv
`timescale 1ns/10ps
`default_nettype none

module axil_mem_sva (
  input  wire                            clk_i,
  input  wire                            rst_n_i,
  input  wire                            bvalid_i,
  input  wire                            bready_i,
  input  wire axil_mem_pkg::axi_resp_e   bresp_i,
  input  wire                            rvalid_i,
  input  wire                            rready_i,
  input  wire axil_mem_pkg::axil_data_t  rdata_i,
  input  wire axil_mem_pkg::axi_resp_e   rresp_i,
  input  wire                            req_v_i,
  input  wire                            rsp_v_i
);

  import axil_mem_pkg::*;

  // Failure tallies per assertion
  int unsigned reset_fail_cnt  = 0;
  int unsigned b_hold_fail_cnt = 0;
  int unsigned r_hold_fail_cnt = 0;
  int unsigned resp_fail_cnt   = 0;

  // Nothing valid while reset is held
  reset_quiet_a : assert property (@(posedge clk_i)
    !rst_n_i |-> !bvalid_i && !rvalid_i && !req_v_i && !rsp_v_i)
    else begin
      $error("valid signal high during reset");
      reset_fail_cnt++;
    end

  // A stalled B response keeps its payload
  b_hold_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else begin
      $error("bvalid dropped or bresp changed before bready");
      b_hold_fail_cnt++;
    end

  // A stalled R response keeps its payload
  r_hold_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
    else begin
      $error("rvalid dropped or R payload changed before rready");
      r_hold_fail_cnt++;
    end

  resp_okay_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bresp_i == OKAY && rresp_i == OKAY)
    else begin
      $error("response code other than OKAY");
      resp_fail_cnt++;
    end

endmodule

bind axil_mem_top axil_mem_sva u_sva (
  .clk_i    (clk_i),
  .rst_n_i  (rst_n_i),
  .bvalid_i (s_axil_bvalid_o),
  .bready_i (s_axil_bready_i),
  .bresp_i  (s_axil_bresp_o),
  .rvalid_i (s_axil_rvalid_o),
  .rready_i (s_axil_rready_i),
  .rdata_i  (s_axil_rdata_o),
  .rresp_i  (s_axil_rresp_o),
  .req_v_i  (req_v),
  .rsp_v_i  (rsp_v)
);

`default_nettype wire

// File: verification/axil_mem_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "axil_mem_defs.svh"

module axil_mem_tb;

  import axil_mem_pkg::*;

  localparam int unsigned clk_period_lp = 8;
  localparam int unsigned burst_len_lp  = 3 * `AXIL_FIFO_ELS;
  localparam int unsigned random_txn_lp = 400;
  // Fill, full word, strobes, alignment, priority, burst, random
  localparam int unsigned txn_count_lp  =
    `MEM_WORDS + 16 + 16 + 6 + 3 + 2 * burst_len_lp + random_txn_lp;
  localparam int unsigned watchdog_ns_lp = (txn_count_lp * 100 + 5) * clk_period_lp;

  logic       clk;
  logic       rst_n;
  axil_addr_t awaddr;
  axi_prot_t  awprot;
  logic       awvalid;
  logic       awready;
  axil_data_t wdata;
  axil_strb_t wstrb;
  logic       wvalid;
  logic       wready;
  axi_resp_e  bresp;
  logic       bvalid;
  logic       bready;
  axil_addr_t araddr;
  axi_prot_t  arprot;
  logic       arvalid;
  logic       arready;
  axil_data_t rdata;
  axi_resp_e  rresp;
  logic       rvalid;
  logic       rready;

  // Reference copy of the scratchpad
  axil_data_t  model_mem [`MEM_WORDS];
  logic [31:0] lfsr_r = 32'h5abeb50c;
  int unsigned cycle_cnt = 0;
  int unsigned last_r_cycle;
  int unsigned last_b_cycle;
  string       cur_test;

  axil_mem_top u_axil_mem_top (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .s_axil_awaddr_i  (awaddr),
    .s_axil_awprot_i  (awprot),
    .s_axil_awvalid_i (awvalid),
    .s_axil_awready_o (awready),
    .s_axil_wdata_i   (wdata),
    .s_axil_wstrb_i   (wstrb),
    .s_axil_wvalid_i  (wvalid),
    .s_axil_wready_o  (wready),
    .s_axil_bresp_o   (bresp),
    .s_axil_bvalid_o  (bvalid),
    .s_axil_bready_i  (bready),
    .s_axil_araddr_i  (araddr),
    .s_axil_arprot_i  (arprot),
    .s_axil_arvalid_i (arvalid),
    .s_axil_arready_o (arready),
    .s_axil_rdata_o   (rdata),
    .s_axil_rresp_o   (rresp),
    .s_axil_rvalid_o  (rvalid),
    .s_axil_rready_i  (rready)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period_lp / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_value(input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      fail_run($sformatf("FAILED %s: expected %h, actual %h", cur_test, expected, actual));
    end
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      val    = {val[30:0], lfsr_r[0]};
      lfsr_r = (lfsr_r >> 1) ^ (lfsr_r[0] ? 32'h8020_0003 : 32'h0);
    end
    return val;
  endfunction

  // Enabled lanes take the new byte
  function automatic axil_data_t merge_bytes(input axil_data_t old_word,
                                             input axil_data_t new_word,
                                             input axil_strb_t strb);
    axil_data_t lane_mask;
    lane_mask = '0;
    for (int b = 0; b < `AXIL_STRB_WIDTH; b++) begin
      lane_mask[8*b +: 8] = {8{strb[b]}};
    end
    return (old_word & ~lane_mask) | (new_word & lane_mask);
  endfunction

  function automatic int unsigned word_index(input axil_addr_t addr);
    return (addr / `AXIL_STRB_WIDTH) % `MEM_WORDS;
  endfunction

  function automatic void model_write(input axil_addr_t addr, input axil_data_t data,
                                      input axil_strb_t strb);
    model_mem[word_index(addr)] = merge_bytes(model_mem[word_index(addr)], data, strb);
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  // Valid holds until ready is seen at the falling edge
  task automatic send_aw(input axil_addr_t addr);
    logic taken;
    awaddr  = addr;
    awvalid = 1'b1;
    do begin
      @(negedge clk);
      taken = awready;
      step();
    end while (!taken);
    awvalid = 1'b0;
  endtask

  task automatic send_w(input axil_data_t data, input axil_strb_t strb);
    logic taken;
    wdata  = data;
    wstrb  = strb;
    wvalid = 1'b1;
    do begin
      @(negedge clk);
      taken = wready;
      step();
    end while (!taken);
    wvalid = 1'b0;
  endtask

  task automatic send_ar(input axil_addr_t addr);
    logic taken;
    araddr  = addr;
    arvalid = 1'b1;
    do begin
      @(negedge clk);
      taken = arready;
      step();
    end while (!taken);
    arvalid = 1'b0;
  endtask

  task automatic wait_b(input bit stall);
    int unsigned gap;
    logic        taken;
    gap = stall ? rand_bits(3) : 0;
    repeat (gap) begin
      step();
    end
    bready = 1'b1;
    do begin
      @(negedge clk);
      taken = bvalid;
      if (taken) begin
        check_value(32'(OKAY), 32'(bresp));
        last_b_cycle = cycle_cnt;
      end
      step();
    end while (!taken);
    bready = 1'b0;
  endtask

  task automatic wait_r(input bit stall, output axil_data_t data);
    int unsigned gap;
    logic        taken;
    gap = stall ? rand_bits(3) : 0;
    repeat (gap) begin
      step();
    end
    rready = 1'b1;
    do begin
      @(negedge clk);
      taken = rvalid;
      if (taken) begin
        check_value(32'(OKAY), 32'(rresp));
        data         = rdata;
        last_r_cycle = cycle_cnt;
      end
      step();
    end while (!taken);
    rready = 1'b0;
  endtask

  task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb, input bit stall);
    fork
      send_aw(addr);
      send_w(data, strb);
    join
    wait_b(stall);
    model_write(addr, data, strb);
  endtask

  task automatic axil_read(input axil_addr_t addr, input bit stall, output axil_data_t data);
    send_ar(addr);
    wait_r(stall, data);
  endtask

  // Every word gets a value built from its full index
  task automatic fill_memory();
    cur_test = "fill";
    for (int i = 0; i < `MEM_WORDS; i++) begin
      axil_write(axil_addr_t'(i * 4), (32'(i) * 32'h9e37_79b1) ^ 32'hc0de_0000, 4'hf, 1'b0);
    end
  endtask

  task automatic test_full_word();
    axil_addr_t addrs [8];
    axil_data_t rd;
    cur_test = "full_word";
    for (int i = 0; i < 8; i++) begin
      addrs[i] = rand_bits(8) * 4;
      axil_write(addrs[i], rand_bits(32), 4'hf, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      axil_read(addrs[i], 1'b0, rd);
      check_value(model_mem[word_index(addrs[i])], rd);
    end
  endtask

  task automatic test_byte_strobe();
    axil_data_t rd;
    cur_test = "byte_strobe";
    for (int i = 0; i < 8; i++) begin
      axil_write(axil_addr_t'((40 + i) * 4), rand_bits(32), axil_strb_t'(i + 1), 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      axil_read(axil_addr_t'((40 + i) * 4), 1'b0, rd);
      check_value(model_mem[40 + i], rd);
    end
  endtask

  task automatic test_align_wrap();
    axil_addr_t addrs [6];
    axil_data_t rd;
    cur_test = "align_wrap";
    addrs = '{32'h21, 32'h22, 32'h23, `MEM_WORDS * 4 + 32'h24, 32'hffff_fffc,
              3 * `MEM_WORDS * 4 + 32'h12};
    for (int i = 0; i < 6; i++) begin
      axil_read(addrs[i], 1'b0, rd);
      check_value(model_mem[word_index(addrs[i])], rd);
    end
  endtask

  // Read sent with AW and W in one cycle sees the old word
  task automatic test_read_priority();
    axil_addr_t addr;
    axil_data_t old_word;
    axil_data_t new_word;
    axil_data_t rd;
    cur_test = "read_priority";
    addr     = 32'h80;
    old_word = model_mem[word_index(addr)];
    new_word = ~old_word;
    fork
      send_aw(addr);
      send_w(new_word, 4'hf);
      send_ar(addr);
    join
    fork
      wait_r(1'b0, rd);
      wait_b(1'b0);
    join
    check_value(old_word, rd);
    check_value(32'd1, 32'(last_r_cycle < last_b_cycle));
    model_write(addr, new_word, 4'hf);
    axil_read(addr, 1'b0, rd);
    check_value(new_word, rd);
  endtask

  // Writes and reads use disjoint words so read data is fixed
  task automatic test_backpressure();
    axil_data_t wdata_a [burst_len_lp];
    axil_data_t rexp_a [burst_len_lp];
    axil_data_t rd;
    logic       stalled;
    cur_test = "backpressure";
    stalled  = 1'b0;
    for (int i = 0; i < burst_len_lp; i++) begin
      wdata_a[i] = rand_bits(32);
      rexp_a[i]  = model_mem[16 + i];
    end
    fork
      for (int i = 0; i < burst_len_lp; i++) begin
        send_aw(axil_addr_t'((192 + i) * 4));
      end
      for (int i = 0; i < burst_len_lp; i++) begin
        send_w(wdata_a[i], 4'hf);
      end
      for (int i = 0; i < burst_len_lp; i++) begin
        send_ar(axil_addr_t'((16 + i) * 4));
      end
      begin
        for (int c = 0; c < 100 && !stalled; c++) begin
          @(negedge clk);
          stalled = !awready || !wready || !arready;
          step();
        end
        if (!stalled) begin
          fail_run("No channel ready dropped while B and R were held");
        end
        fork
          for (int i = 0; i < burst_len_lp; i++) begin
            wait_b(1'b0);
          end
          for (int i = 0; i < burst_len_lp; i++) begin
            wait_r(1'b0, rd);
            check_value(rexp_a[i], rd);
          end
        join
      end
    join
    for (int i = 0; i < burst_len_lp; i++) begin
      model_write(axil_addr_t'((192 + i) * 4), wdata_a[i], 4'hf);
    end
  endtask

  task automatic test_random();
    axil_addr_t addr;
    axil_data_t data;
    axil_strb_t strb;
    cur_test = "random";
    for (int i = 0; i < random_txn_lp; i++) begin
      addr = rand_bits(12);
      if (rand_bits(1) == 32'd1) begin
        data = rand_bits(32);
        strb = axil_strb_t'(rand_bits(4));
        axil_write(addr, data, strb, 1'b1);
      end else begin
        axil_read(addr, 1'b1, data);
        check_value(model_mem[word_index(addr)], data);
      end
    end
  endtask

  function automatic int unsigned sva_failures();
    return u_axil_mem_top.u_sva.reset_fail_cnt + u_axil_mem_top.u_sva.b_hold_fail_cnt +
           u_axil_mem_top.u_sva.r_hold_fail_cnt + u_axil_mem_top.u_sva.resp_fail_cnt;
  endfunction

  initial begin
    #(watchdog_ns_lp);
    fail_run($sformatf("Simulation hung, watchdog expired at %0t", $time));
  end

  initial begin
    awaddr  = '0;
    awprot  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arprot  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    rst_n   = 1'b0;
    repeat (5) begin
      @(posedge clk);
    end
    #1;
    rst_n = 1'b1;
    step();
    fill_memory();
    test_full_word();
    test_byte_strobe();
    test_align_wrap();
    test_read_priority();
    test_backpressure();
    test_random();
    if (sva_failures() != 0) begin
      fail_run("Bound assertions reported failures");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: axil_mem_top.f
+incdir+src
src/axil_mem_pkg.sv
src/axil_fifo.sv
src/axil_fifo_client.sv
src/axil_scratch_mem.sv
src/axil_mem_top.sv
verification/axil_mem_sva.sv
verification/axil_mem_tb.sv

// File: Makefile
# Verilator simulation of the AXI4-Lite scratchpad

VERILATOR ?= verilator
TOP       ?= axil_mem_tb
FILELIST  ?= axil_mem_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
